//--- hdl/glb_pkg.sv
// bank geometry and packet formats shared by the global buffer bank RTL and its testbench
package glb_pkg;

    // word address into one bank
    localparam int bank_addr_width = 10;
    // words per bank
    localparam int bank_depth = 1 << bank_addr_width;
    // 64-bit words
    localparam int bank_data_width = 64;
    // one strobe per byte lane
    localparam int bank_strb_width = bank_data_width / 8;

    // write packet, valid-only, no handshake
    // 83 bits: en + strb + addr + data
    typedef struct packed {
        logic                       wr_en;
        logic [bank_strb_width-1:0] wr_strb;
        logic [bank_addr_width-1:0] wr_addr;
        logic [bank_data_width-1:0] wr_data;
    } wr_packet_t;

    // read request packet
    // 11 bits: en + addr
    typedef struct packed {
        logic                       rd_en;
        logic [bank_addr_width-1:0] rd_addr;
    } rdrq_packet_t;

    // read response packet
    // one per accepted read, in issue order
    typedef struct packed {
        logic                       rd_data_valid;
        logic [bank_data_width-1:0] rd_data;
    } rdrs_packet_t;

endpackage

//--- hdl/glb_cfg_pkg.sv
// configuration port formats for the bank: request word, address views and register map
package glb_cfg_pkg;

    // full config address, space bit on top
    localparam int cfg_addr_width = 12;
    // register index inside the register space
    localparam int cfg_reg_idx_width = 2;
    // write counter width, saturates at all ones
    localparam int cfg_count_width = 16;

    // space bit values
    localparam logic cfg_space_reg  = 1'b0;
    localparam logic cfg_space_sram = 1'b1;

    // register indices
    localparam logic [cfg_reg_idx_width-1:0] cfg_reg_ctrl     = 2'd0;
    localparam logic [cfg_reg_idx_width-1:0] cfg_reg_wr_count = 2'd1;

    // same 12-bit word, read as sram address or as register index
    typedef union packed {
        struct packed {
            logic                                             space;
            logic [cfg_addr_width-2-glb_pkg::bank_addr_width:0] pad;
            logic [glb_pkg::bank_addr_width-1:0]              addr;
        } mem;
        struct packed {
            logic                                       space;
            logic [cfg_addr_width-2-cfg_reg_idx_width:0] pad;
            logic [cfg_reg_idx_width-1:0]               idx;
        } regs;
    } cfg_addr_u;

    // request from the config master, held stable while cfg_req is high
    typedef struct packed {
        cfg_addr_u                           addr;
        logic                                wr;
        logic [glb_pkg::bank_data_width-1:0] wdata;
    } cfg_req_t;

    // sram access forwarded from the register block to the bank controller
    typedef struct packed {
        logic                                valid;
        logic                                wr;
        logic [glb_pkg::bank_addr_width-1:0] addr;
        logic [glb_pkg::bank_data_width-1:0] wdata;
    } cfg_sram_req_t;

endpackage

//--- hdl/glb_bank_memory.sv
// behavioral simple dual-port SRAM for one bank, bit-masked write and registered read
`timescale 1ns/10ps

module glb_bank_memory (
    input  logic                                clk,

    // read port
    input  logic                                ren,
    input  logic [glb_pkg::bank_addr_width-1:0] raddr,

    // write port
    input  logic                                wen,
    input  logic [glb_pkg::bank_addr_width-1:0] waddr,
    input  logic [glb_pkg::bank_data_width-1:0] data_in,
    input  logic [glb_pkg::bank_data_width-1:0] bit_sel,

    output logic [glb_pkg::bank_data_width-1:0] data_out
);

    import glb_pkg::*;

    // storage, contents undefined after reset
    logic [bank_data_width-1:0] mem_array [bank_depth];

    // merged word for the write port
    logic [bank_data_width-1:0] wr_word;

    // keep old bits where bit_sel is 0
    always_comb begin
        wr_word = (mem_array[waddr] & ~bit_sel) | (data_in & bit_sel);
    end

    // write port
    always_ff @(posedge clk) begin
        if (wen) begin
            mem_array[waddr] <= wr_word;
        end
    end

    // read port, one cycle latency
    // same-edge write is not visible here, read returns old word
    always_ff @(posedge clk) begin
        if (ren) begin
            data_out <= mem_array[raddr];
        end
    end

endmodule

//--- hdl/glb_bank_ctrl.sv
// bank controller: arbitrates packet and config SRAM traffic onto the memory ports
`timescale 1ns/10ps

module glb_bank_ctrl (
    input  logic                                 clk,
    input  logic                                 rst_n,

    // packet ports
    input  glb_pkg::wr_packet_t                  wr_packet,
    input  glb_pkg::rdrq_packet_t                rdrq_packet,
    output glb_pkg::rdrs_packet_t                rdrs_packet,

    // from and to the register block
    input  logic                                 bank_en,
    input  glb_cfg_pkg::cfg_sram_req_t           sram_req,
    output logic                                 sram_done,
    output logic [glb_pkg::bank_data_width-1:0]  sram_rdata,
    output logic                                 wr_accepted,

    // memory ports
    output logic                                 mem_ren,
    output logic [glb_pkg::bank_addr_width-1:0]  mem_raddr,
    output logic                                 mem_wen,
    output logic [glb_pkg::bank_addr_width-1:0]  mem_waddr,
    output logic [glb_pkg::bank_data_width-1:0]  mem_data_in,
    output logic [glb_pkg::bank_data_width-1:0]  mem_bit_sel,
    input  logic [glb_pkg::bank_data_width-1:0]  mem_data_out
);

    import glb_pkg::*;

    // packets after the enable gate
    wr_packet_t   wr_acc;
    rdrq_packet_t rd_acc;

    // stage 1, registered accepted packets
    wr_packet_t   wr_q;
    rdrq_packet_t rd_q;

    // byte strobes expanded to bits
    logic [bank_data_width-1:0] strb_mask;

    // config grants on each memory port
    logic cfg_wr_grant;
    logic cfg_rd_grant;
    // config access already issued, waiting for sram_done to be seen
    logic cfg_busy;

    // stage 2 tags, owner of the memory access
    logic pkt_rd_tag_q;
    logic cfg_rd_tag_q;
    logic cfg_wr_done_q;

    // drop packets while the bank is disabled
    always_comb begin
        wr_acc       = wr_packet;
        wr_acc.wr_en = wr_packet.wr_en & bank_en;
        rd_acc       = rdrq_packet;
        rd_acc.rd_en = rdrq_packet.rd_en & bank_en;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_q <= '0;
            rd_q <= '0;
        end else begin
            wr_q <= wr_acc;
            rd_q <= rd_acc;
        end
    end

    // one strobe bit covers eight data bits
    always_comb begin
        for (int i = 0; i < bank_strb_width; i++) begin
            strb_mask[i*8 +: 8] = {8{wr_q.wr_strb[i]}};
        end
    end

    // packets first, config only on an idle port
    assign cfg_busy     = cfg_rd_tag_q | cfg_wr_done_q;
    assign cfg_wr_grant = sram_req.valid & sram_req.wr & ~wr_q.wr_en & ~cfg_busy;
    assign cfg_rd_grant = sram_req.valid & ~sram_req.wr & ~rd_q.rd_en & ~cfg_busy;

    // write port mux, config writes take the whole word
    assign mem_wen     = wr_q.wr_en | cfg_wr_grant;
    assign mem_waddr   = wr_q.wr_en ? wr_q.wr_addr : sram_req.addr;
    assign mem_data_in = wr_q.wr_en ? wr_q.wr_data : sram_req.wdata;
    assign mem_bit_sel = wr_q.wr_en ? strb_mask : '1;

    // read port mux
    assign mem_ren   = rd_q.rd_en | cfg_rd_grant;
    assign mem_raddr = rd_q.rd_en ? rd_q.rd_addr : sram_req.addr;

    // tags travel alongside the memory read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pkt_rd_tag_q  <= 1'b0;
            cfg_rd_tag_q  <= 1'b0;
            cfg_wr_done_q <= 1'b0;
        end else begin
            pkt_rd_tag_q  <= rd_q.rd_en;
            cfg_rd_tag_q  <= cfg_rd_grant;
            cfg_wr_done_q <= cfg_wr_grant;
        end
    end

    // packet response, two cycles after rd_en is sampled
    assign rdrs_packet.rd_data_valid = pkt_rd_tag_q;
    assign rdrs_packet.rd_data       = mem_data_out;

    // config completion, one pulse per forwarded access
    assign sram_done  = cfg_rd_tag_q | cfg_wr_done_q;
    assign sram_rdata = mem_data_out;

    // counts at stage 1, once per accepted write
    assign wr_accepted = wr_q.wr_en;

endmodule

//--- hdl/glb_cfg_regs.sv
// four-phase configuration slave with bank control and status registers and SRAM forwarding
`timescale 1ns/10ps

module glb_cfg_regs (
    input  logic                                clk,
    input  logic                                rst_n,

    // config master side
    input  logic                                cfg_req,
    input  glb_cfg_pkg::cfg_req_t               cfg,
    output logic                                cfg_ack,
    output logic [glb_pkg::bank_data_width-1:0] cfg_rdata,

    // status from the controller
    input  logic                                wr_accepted,

    // forwarded sram access
    output glb_cfg_pkg::cfg_sram_req_t          sram_req,
    input  logic                                sram_done,
    input  logic [glb_pkg::bank_data_width-1:0] sram_rdata,

    // control to the controller
    output logic                                bank_en
);

    import glb_pkg::*;
    import glb_cfg_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_reg,
        st_sram,
        st_ack
    } state_t;

    state_t state;

    // saturating count of accepted packet writes
    logic [cfg_count_width-1:0] wr_count;

    // register read mux
    logic [bank_data_width-1:0] reg_rdata;

    // unused indices read as zero
    always_comb begin
        case (cfg.addr.regs.idx)
            cfg_reg_ctrl:     reg_rdata = bank_data_width'(bank_en);
            cfg_reg_wr_count: reg_rdata = bank_data_width'(wr_count);
            default:          reg_rdata = '0;
        endcase
    end

    // handshake FSM and control registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= st_idle;
            bank_en <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    // space bit picks registers or sram
                    if (cfg_req) begin
                        if (cfg.addr.regs.space == cfg_space_sram) begin
                            state <= st_sram;
                        end else begin
                            state <= st_reg;
                        end
                    end
                end
                st_reg: begin
                    // only the control register is writable
                    if (cfg.wr && cfg.addr.regs.idx == cfg_reg_ctrl) begin
                        bank_en <= cfg.wdata[0];
                    end
                    state <= st_ack;
                end
                st_sram: begin
                    // wait as long as packets hold the port
                    if (sram_done) begin
                        state <= st_ack;
                    end
                end
                default: begin
                    // ack held until the master lets go
                    if (!cfg_req) begin
                        state <= st_idle;
                    end
                end
            endcase
        end
    end

    // write counter, stops at all ones
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_count <= '0;
        end else if (wr_accepted && wr_count != '1) begin
            wr_count <= wr_count + 1'b1;
        end
    end

    // read data for the master
    always_ff @(posedge clk) begin
        if (state == st_reg) begin
            cfg_rdata <= reg_rdata;
        end else if (state == st_sram && sram_done && !cfg.wr) begin
            cfg_rdata <= sram_rdata;
        end
    end

    assign cfg_ack = (state == st_ack);

    // cfg is stable for the whole access, forward it directly
    always_comb begin
        sram_req.valid = (state == st_sram);
        sram_req.wr    = cfg.wr;
        sram_req.addr  = cfg.addr.mem.addr;
        sram_req.wdata = cfg.wdata;
    end

endmodule

//--- hdl/glb_bank.sv
// one global buffer bank: config registers, bank controller and SRAM wired together
`timescale 1ns/10ps

module glb_bank (
    input  logic                                clk,
    input  logic                                rst_n,

    // packet traffic
    input  glb_pkg::wr_packet_t                 wr_packet,
    input  glb_pkg::rdrq_packet_t               rdrq_packet,
    output glb_pkg::rdrs_packet_t               rdrs_packet,

    // four-phase config port
    input  logic                                cfg_req,
    input  glb_cfg_pkg::cfg_req_t               cfg,
    output logic                                cfg_ack,
    output logic [glb_pkg::bank_data_width-1:0] cfg_rdata
);

    import glb_pkg::*;
    import glb_cfg_pkg::*;

    // register block to controller
    logic          bank_en;
    logic          wr_accepted;
    cfg_sram_req_t sram_req;
    logic          sram_done;
    logic [bank_data_width-1:0] sram_rdata;

    // controller to memory
    logic                       mem_ren;
    logic [bank_addr_width-1:0] mem_raddr;
    logic                       mem_wen;
    logic [bank_addr_width-1:0] mem_waddr;
    logic [bank_data_width-1:0] mem_data_in;
    logic [bank_data_width-1:0] mem_bit_sel;
    logic [bank_data_width-1:0] mem_data_out;

    glb_cfg_regs glb_cfg_regs_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg_req     (cfg_req),
        .cfg         (cfg),
        .cfg_ack     (cfg_ack),
        .cfg_rdata   (cfg_rdata),
        .wr_accepted (wr_accepted),
        .sram_req    (sram_req),
        .sram_done   (sram_done),
        .sram_rdata  (sram_rdata),
        .bank_en     (bank_en)
    );

    glb_bank_ctrl glb_bank_ctrl_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .wr_packet    (wr_packet),
        .rdrq_packet  (rdrq_packet),
        .rdrs_packet  (rdrs_packet),
        .bank_en      (bank_en),
        .sram_req     (sram_req),
        .sram_done    (sram_done),
        .sram_rdata   (sram_rdata),
        .wr_accepted  (wr_accepted),
        .mem_ren      (mem_ren),
        .mem_raddr    (mem_raddr),
        .mem_wen      (mem_wen),
        .mem_waddr    (mem_waddr),
        .mem_data_in  (mem_data_in),
        .mem_bit_sel  (mem_bit_sel),
        .mem_data_out (mem_data_out)
    );

    glb_bank_memory glb_bank_memory_inst (
        .clk      (clk),
        .ren      (mem_ren),
        .raddr    (mem_raddr),
        .wen      (mem_wen),
        .waddr    (mem_waddr),
        .data_in  (mem_data_in),
        .bit_sel  (mem_bit_sel),
        .data_out (mem_data_out)
    );

endmodule

//--- test/glb_bank_asserts.sv
// concurrent checks on the config handshake and packet read latency, bound into the bank top level
`timescale 1ns/10ps

module glb_bank_asserts (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  cfg_req,
    input logic                  cfg_ack,
    input logic                  bank_en,
    input glb_pkg::rdrq_packet_t rdrq_packet,
    input glb_pkg::rdrs_packet_t rdrs_packet
);

    // read taken by the controller at this edge
    logic rd_accept;

    assign rd_accept = rdrq_packet.rd_en & bank_en;

    // ack only answers a live request
    ack_needs_req: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(cfg_ack) |-> cfg_req
    ) else $error("cfg_ack rose while cfg_req was low");

    // ack held until the master lets go
    ack_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        cfg_ack && cfg_req |=> cfg_ack
    ) else $error("cfg_ack dropped before cfg_req fell");

    // no new request on top of an old ack
    req_after_ack: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(cfg_req) |-> !cfg_ack
    ) else $error("cfg_req rose while cfg_ack was still high");

    // response two cycles after the accepted read, and never without one
    rd_latency: assert property (
        @(posedge clk) disable iff (!rst_n)
        rd_accept |-> ##2 rdrs_packet.rd_data_valid
    ) else $error("rd_data_valid missing two cycles after an accepted read");

    rd_no_orphan: assert property (
        @(posedge clk) disable iff (!rst_n)
        rdrs_packet.rd_data_valid |-> $past(rd_accept, 2)
    ) else $error("rd_data_valid without an accepted read two cycles before");

endmodule

bind glb_bank glb_bank_asserts glb_bank_asserts_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .cfg_req     (cfg_req),
    .cfg_ack     (cfg_ack),
    .bank_en     (bank_en),
    .rdrq_packet (rdrq_packet),
    .rdrs_packet (rdrs_packet)
);

//--- test/glb_bank_tb.sv
// testbench for one global buffer bank: seeded random packet and config traffic against a model
`timescale 1ns/10ps

module glb_bank_tb;

    import glb_pkg::*;
    import glb_cfg_pkg::*;

    // predicted packet response and the cycle its read was issued
    typedef struct packed {
        logic [bank_data_width-1:0] data;
        logic [31:0]                cycle;
    } expect_t;

    // transactions per test
    localparam int n_dis   = 4;
    localparam int n_cfg   = 16;
    localparam int n_seq   = 48;
    localparam int n_mix   = 200;
    localparam int n_bg    = 120;
    localparam int n_bgcfg = 12;
    // worst case per transaction is a config access stalled by packets
    localparam int max_txn_cycles = 12;
    localparam int timeout_cycles =
        (n_dis + 5 + 2 * n_cfg + 2 * n_seq + n_mix + n_bg + n_bgcfg + n_cfg + n_bgcfg + 1)
        * max_txn_cycles + 200;

    logic                       clk = 1'b0;
    logic                       rst_n;
    wr_packet_t                 wr_packet;
    rdrq_packet_t               rdrq_packet;
    rdrs_packet_t               rdrs_packet;
    logic                       cfg_req;
    cfg_req_t                   cfg;
    logic                       cfg_ack;
    logic [bank_data_width-1:0] cfg_rdata;

    // reference model
    logic [bank_data_width-1:0] model_mem [int];
    int unsigned                model_count;
    logic                       model_bank_en;
    expect_t                    expect_q [$];
    // packets use the low half, config the high half
    int                         pkt_addrs [$];
    int                         cfg_addrs [$];

    int          seed = 32'h983b_f555;
    int unsigned cycle = 0;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    expect_t     rsp_exp;

    glb_bank glb_bank_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr_packet   (wr_packet),
        .rdrq_packet (rdrq_packet),
        .rdrs_packet (rdrs_packet),
        .cfg_req     (cfg_req),
        .cfg         (cfg),
        .cfg_ack     (cfg_ack),
        .cfg_rdata   (cfg_rdata)
    );

    // 40 ns period
    always #20 clk = ~clk;

    // cycle count and watchdog
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= timeout_cycles) begin
            $display("timeout after %0d cycles, a handshake or read response never came", cycle);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("error %0t %s expected %h actual %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    // responses come back in issue order, two cycles after the read
    always @(negedge clk) begin
        if (rst_n === 1'b1 && rdrs_packet.rd_data_valid === 1'b1) begin
            checks++;
            assert (expect_q.size() != 0) else begin
                $display("read response at %0t with no packet read outstanding", $time);
                errors++;
            end
            if (expect_q.size() != 0) begin
                rsp_exp = expect_q.pop_front();
                check_value("rdrs_packet.rd_data", rsp_exp.data, rdrs_packet.rd_data);
                check_value("rd_data_valid cycle", 64'(rsp_exp.cycle + 2), 64'(cycle));
            end
        end
    end

    function automatic int random_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic [63:0] random_word();
        return {$random(seed), $random(seed)};
    endfunction

    // byte lanes with strobe set take the new data
    function automatic logic [63:0] merge_bytes(input logic [63:0] old_word,
                                                input logic [63:0] new_word,
                                                input logic [7:0] strb);
        logic [63:0] result;
        result = old_word;
        for (int i = 0; i < bank_strb_width; i++) begin
            if (strb[i]) begin
                result[i*8 +: 8] = new_word[i*8 +: 8];
            end
        end
        return result;
    endfunction

    task automatic drive_cycle(input logic wr_en, input logic [9:0] waddr,
                               input logic [7:0] strb, input logic [63:0] wdata,
                               input logic rd_en, input logic [9:0] raddr);
        expect_t     rsp;
        logic [63:0] old_word;
        @(posedge clk);
        #2;
        wr_packet   = '{wr_en: wr_en, wr_strb: strb, wr_addr: waddr, wr_data: wdata};
        rdrq_packet = '{rd_en: rd_en, rd_addr: raddr};
        if (model_bank_en) begin
            // read sees earlier writes only, same-cycle write goes in after
            if (rd_en) begin
                rsp.data  = model_mem[raddr];
                rsp.cycle = cycle;
                expect_q.push_back(rsp);
            end
            if (wr_en) begin
                old_word = '0;
                if (model_mem.exists(waddr)) begin
                    old_word = model_mem[waddr];
                end else begin
                    pkt_addrs.push_back(waddr);
                end
                model_mem[waddr] = merge_bytes(old_word, wdata, strb);
                model_count++;
            end
        end
    endtask

    task automatic random_cycle(input logic do_wr, input logic do_rd, input logic same_addr);
        logic [9:0] raddr;
        logic [9:0] waddr;
        logic [7:0] strb;
        logic       rd_en;
        rd_en = do_rd && pkt_addrs.size() != 0;
        raddr = '0;
        if (rd_en) begin
            raddr = 10'(pkt_addrs[random_below(pkt_addrs.size())]);
        end
        if (rd_en && same_addr) begin
            waddr = raddr;
        end else if (pkt_addrs.size() != 0 && random_below(2) == 0) begin
            waddr = 10'(pkt_addrs[random_below(pkt_addrs.size())]);
        end else begin
            waddr = 10'(random_below(512));
        end
        strb = 8'($random(seed));
        // first write to a word covers all of it
        if (!model_mem.exists(waddr)) begin
            strb = '1;
        end
        drive_cycle(do_wr, waddr, strb, random_word(), rd_en, raddr);
    endtask

    // idle the packet ports and wait out every response
    task automatic drain();
        drive_cycle(1'b0, '0, '0, '0, 1'b0, '0);
        while (expect_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
    endtask

    function automatic cfg_addr_u sram_addr(input int a);
        cfg_addr_u u;
        u          = '0;
        u.mem.space = cfg_space_sram;
        u.mem.addr  = 10'(a);
        return u;
    endfunction

    function automatic cfg_addr_u reg_addr(input logic [1:0] idx);
        cfg_addr_u u;
        u           = '0;
        u.regs.space = cfg_space_reg;
        u.regs.idx   = idx;
        return u;
    endfunction

    // one four-phase access, latency counted from the cycle req goes up
    task automatic cfg_access(input logic wr, input cfg_addr_u addr, input logic [63:0] wdata,
                              output logic [63:0] rdata, output int latency);
        int unsigned start;
        @(posedge clk);
        #2;
        checks++;
        assert (cfg_ack === 1'b0) else begin
            $display("cfg_ack still high at %0t when a new request was due", $time);
            errors++;
        end
        cfg.addr  = addr;
        cfg.wr    = wr;
        cfg.wdata = wdata;
        cfg_req   = 1'b1;
        start     = cycle;
        @(negedge clk);
        while (!cfg_ack) begin
            @(negedge clk);
        end
        rdata   = cfg_rdata;
        latency = int'(cycle - start);
        @(posedge clk);
        #2;
        cfg_req = 1'b0;
        @(negedge clk);
        while (cfg_ack) begin
            @(negedge clk);
        end
    endtask

    task automatic sram_write(input int a, input logic [63:0] data);
        logic [63:0] rdata;
        int          lat;
        if (!model_mem.exists(a)) begin
            cfg_addrs.push_back(a);
        end
        model_mem[a] = data;
        cfg_access(1'b1, sram_addr(a), data, rdata, lat);
    endtask

    task automatic sram_read(input int a);
        logic [63:0] rdata;
        logic [63:0] expected;
        int          lat;
        expected = model_mem[a];
        cfg_access(1'b0, sram_addr(a), '0, rdata, lat);
        check_value("cfg_rdata", expected, rdata);
    endtask

    task automatic reg_read(input logic [1:0] idx, input logic [63:0] expected);
        logic [63:0] rdata;
        int          lat;
        cfg_access(1'b0, reg_addr(idx), '0, rdata, lat);
        check_value("cfg_rdata", expected, rdata);
        check_value("cfg_ack latency", 64'd2, 64'(lat));
    endtask

    task automatic reg_write(input logic [1:0] idx, input logic [63:0] data);
        logic [63:0] rdata;
        int          lat;
        cfg_access(1'b1, reg_addr(idx), data, rdata, lat);
        if (idx == cfg_reg_ctrl) begin
            model_bank_en = data[0];
        end
    endtask

    task automatic end_test(input string name, input int err_start);
        tests++;
        if (errors == err_start) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errors - err_start);
        end
    endtask

    initial begin
        int err_start;
        wr_packet     = '0;
        rdrq_packet   = '0;
        cfg_req       = 1'b0;
        cfg           = '0;
        rst_n         = 1'b0;
        model_count   = 0;
        model_bank_en = 1'b0;
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;

        // disabled bank drops packets, then enable it
        err_start = errors;
        @(negedge clk);
        check_value("cfg_ack", 64'd0, 64'(cfg_ack));
        check_value("rd_data_valid", 64'd0, 64'(rdrs_packet.rd_data_valid));
        for (int i = 0; i < n_dis; i++) begin
            drive_cycle(1'b1, 10'(i), '1, random_word(), 1'b1, 10'(i));
        end
        drain();
        reg_read(cfg_reg_wr_count, 64'd0);
        reg_read(2'd3, 64'd0);
        reg_write(cfg_reg_ctrl, 64'd1);
        reg_read(cfg_reg_ctrl, 64'd1);
        end_test("reset and bank enable", err_start);

        // config sram writes and read back
        err_start = errors;
        for (int i = 0; i < n_cfg; i++) begin
            sram_write(512 + random_below(512), random_word());
        end
        for (int i = 0; i < n_cfg; i++) begin
            sram_read(cfg_addrs[random_below(cfg_addrs.size())]);
        end
        end_test("config sram access", err_start);

        // strobed writes, then reads
        err_start = errors;
        for (int i = 0; i < n_seq; i++) begin
            random_cycle(1'b1, 1'b0, 1'b0);
        end
        for (int i = 0; i < n_seq; i++) begin
            random_cycle(1'b0, 1'b1, 1'b0);
        end
        drain();
        end_test("packet write then read", err_start);

        // reads and writes together, some to the same word
        err_start = errors;
        for (int i = 0; i < n_mix; i++) begin
            random_cycle(random_below(2) == 0, random_below(2) == 0, random_below(4) == 0);
        end
        drain();
        end_test("mixed packet traffic", err_start);

        // config accesses racing packet traffic on the other half
        err_start = errors;
        fork
            begin
                for (int i = 0; i < n_bg; i++) begin
                    random_cycle(random_below(2) == 0, random_below(2) == 0, 1'b0);
                end
                drive_cycle(1'b0, '0, '0, '0, 1'b0, '0);
            end
            begin
                for (int i = 0; i < n_bgcfg; i++) begin
                    if (i % 2 == 0) begin
                        sram_write(512 + random_below(512), random_word());
                    end else begin
                        sram_read(cfg_addrs[random_below(cfg_addrs.size())]);
                    end
                end
            end
        join
        drain();
        // packet reads see what config wrote
        foreach (cfg_addrs[i]) begin
            drive_cycle(1'b0, '0, '0, '0, 1'b1, 10'(cfg_addrs[i]));
        end
        drain();
        end_test("config access under traffic", err_start);

        // accepted write count
        err_start = errors;
        reg_read(cfg_reg_wr_count, 64'(model_count));
        end_test("write counter", err_start);

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- src.f
hdl/glb_pkg.sv
hdl/glb_cfg_pkg.sv
hdl/glb_bank_memory.sv
hdl/glb_bank_ctrl.sv
hdl/glb_cfg_regs.sv
hdl/glb_bank.sv
test/glb_bank_asserts.sv
test/glb_bank_tb.sv

//--- Makefile
# Verilator build and run of the bank testbench

LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module glb_bank_tb -f src.f
	./obj_dir/Vglb_bank_tb | tee $(LOG)
	grep -q "^TEST PASSED$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
